//--- rtl/cpu_pkg.sv
package cpu_pkg;

  // instruction word fields
  localparam int IR_TYPE_MSB = 31;
  localparam int IR_TYPE_LSB = 28;
  localparam int IR_OP_MSB   = 27;
  localparam int IR_OP_LSB   = 24;
  localparam int IR_RA_MSB   = 23;
  localparam int IR_RA_LSB   = 20;

  localparam logic [3:0] LINK_REG = 4'd13; // %13 takes the return address

  // write-back modes
  localparam logic [1:0] WB_NONE = 2'd0;
  localparam logic [1:0] WB_BOTH = 2'd3;

  localparam logic [31:0] LINK_OFFSET = 32'd4;

  // instruction class, bits 31..28
  typedef enum logic [3:0] {
    T_INH    = 4'h0,
    T_ALU    = 4'h1,
    T_LOAD   = 4'h2,
    T_STORE  = 4'h3,
    T_BRANCH = 4'h4,
    T_JUMP   = 4'h5
  } ir_type_e;

  // access size, low opcode bits 25..24
  typedef enum logic [1:0] {
    SZ_WORD     = 2'h0,
    SZ_HALF     = 2'h1,
    SZ_BYTE     = 2'h2,
    SZ_WORD_ALT = 2'h3 // handled as a word
  } mem_size_e;

endpackage

//--- rtl/mem_bus_ctrl.sv
`timescale 1ns/1ns

module mem_bus_ctrl (
  input  logic [63:0] ir_i,
  input  logic [31:0] result_i,
  input  logic [31:0] reg_data1_i,
  input  logic        exc_i,
  input  logic        bus_ack_i,
  input  logic [31:0] bus_dat_i,
  output logic        bus_cyc_o,
  output logic        bus_we_o,
  output logic [31:0] bus_adr_o,
  output logic [31:0] bus_dat_o,
  output logic [3:0]  bus_sel_o,
  output logic [31:0] load_data_o,
  output logic        bus_stall_o
);

  cpu_pkg::ir_type_e  ir_type;
  cpu_pkg::mem_size_e ir_size;
  logic [3:0]         ir_op;
  logic               is_mem;

  assign ir_type = cpu_pkg::ir_type_e'(ir_i[cpu_pkg::IR_TYPE_MSB:cpu_pkg::IR_TYPE_LSB]);
  assign ir_op   = ir_i[cpu_pkg::IR_OP_MSB:cpu_pkg::IR_OP_LSB];
  assign ir_size = cpu_pkg::mem_size_e'(ir_op[1:0]);

  assign is_mem = (ir_type == cpu_pkg::T_LOAD) || (ir_type == cpu_pkg::T_STORE);

  // an exception never reaches the bus
  assign bus_cyc_o = is_mem && !exc_i;
  assign bus_we_o  = bus_cyc_o && (ir_type == cpu_pkg::T_STORE);
  assign bus_adr_o = result_i;
  assign bus_dat_o = reg_data1_i;

  assign bus_stall_o = bus_cyc_o && !bus_ack_i; // waiting on ack

  // big-endian lanes, lane 3 is the top byte
  always_comb
  begin
    case (ir_size)
      cpu_pkg::SZ_WORD:     bus_sel_o = 4'b1111;
      cpu_pkg::SZ_WORD_ALT: bus_sel_o = 4'b1111;
      cpu_pkg::SZ_HALF:     bus_sel_o = result_i[1] ? 4'b0011 : 4'b1100;
      cpu_pkg::SZ_BYTE:
      begin
        case (result_i[1:0])
          2'b00: bus_sel_o = 4'b1000;
          2'b01: bus_sel_o = 4'b0100;
          2'b10: bus_sel_o = 4'b0010;
          2'b11: bus_sel_o = 4'b0001;
        endcase
      end
    endcase
  end

  // shift the selected lanes down, zero fill
  always_comb
  begin
    case (ir_size)
      cpu_pkg::SZ_WORD:     load_data_o = bus_dat_i;
      cpu_pkg::SZ_WORD_ALT: load_data_o = bus_dat_i;
      cpu_pkg::SZ_HALF:
      begin
        if (result_i[1])
          load_data_o = {16'h0000, bus_dat_i[15:0]};
        else
          load_data_o = {16'h0000, bus_dat_i[31:16]};
      end
      cpu_pkg::SZ_BYTE:
      begin
        case (result_i[1:0])
          2'b00: load_data_o = {24'h000000, bus_dat_i[31:24]};
          2'b01: load_data_o = {24'h000000, bus_dat_i[23:16]};
          2'b10: load_data_o = {24'h000000, bus_dat_i[15:8]};
          2'b11: load_data_o = {24'h000000, bus_dat_i[7:0]};
        endcase
      end
    endcase
  end

  // combinational block, checked once the inputs settle
  always_comb
  begin
    assert final (!bus_cyc_o || bus_sel_o != 4'h0)
      else $error("bus cycle with no byte lane selected");
  end

endmodule

//--- rtl/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        stall_i,
  output logic        stall_o,
  input  logic        halt_i,
  output logic        halt_o,
  input  logic [31:0] result_i,
  output logic [31:0] result_o,
  input  logic [31:0] reg_data1_i,
  input  logic [1:0]  reg_write_i,
  output logic [1:0]  reg_write_o,
  input  logic [31:0] pc_i,
  output logic [31:0] pc_o,
  input  logic        pc_set_i,
  output logic        pc_set_o,
  input  logic [63:0] ir_i,
  output logic [63:0] ir_o,
  output logic [3:0]  reg_write_addr_o,
  input  logic [3:0]  bank_i,
  output logic [3:0]  bank_o,
  input  logic        exc_i,
  output logic        exc_o,
  output logic [31:0] bus_adr_o,
  output logic        bus_we_o,
  output logic        bus_cyc_o,
  input  logic        bus_ack_i,
  input  logic [31:0] bus_dat_i,
  output logic [31:0] bus_dat_o,
  output logic [3:0]  bus_sel_o
);

  logic [31:0] load_data;
  logic        bus_stall;
  logic [3:0]  wb_addr;
  logic [1:0]  wb_mode;
  logic [31:0] pc_next;
  logic        pc_set_next;
  logic        link_sel;
  logic        load_sel;
  logic [31:0] link_value;

  assign stall_o = bus_stall; // holds the earlier stages

  mem_bus_ctrl u_bus_ctrl (
    .ir_i        (ir_i),
    .result_i    (result_i),
    .reg_data1_i (reg_data1_i),
    .exc_i       (exc_i),
    .bus_ack_i   (bus_ack_i),
    .bus_dat_i   (bus_dat_i),
    .bus_cyc_o   (bus_cyc_o),
    .bus_we_o    (bus_we_o),
    .bus_adr_o   (bus_adr_o),
    .bus_dat_o   (bus_dat_o),
    .bus_sel_o   (bus_sel_o),
    .load_data_o (load_data),
    .bus_stall_o (bus_stall)
  );

  mem_wb_decode u_wb_decode (
    .ir_i          (ir_i),
    .pc_i          (pc_i),
    .result_i      (result_i),
    .exc_i         (exc_i),
    .reg_write_i   (reg_write_i),
    .pc_set_i      (pc_set_i),
    .wb_addr_o     (wb_addr),
    .wb_mode_o     (wb_mode),
    .pc_next_o     (pc_next),
    .pc_set_next_o (pc_set_next),
    .link_sel_o    (link_sel),
    .load_sel_o    (load_sel),
    .link_value_o  (link_value)
  );

  mem_stage_reg u_stage_reg (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .stall_i          (stall_i),
    .bus_stall_i      (bus_stall),
    .result_i         (result_i),
    .load_data_i      (load_data),
    .link_value_i     (link_value),
    .link_sel_i       (link_sel),
    .load_sel_i       (load_sel),
    .wb_addr_i        (wb_addr),
    .wb_mode_i        (wb_mode),
    .pc_next_i        (pc_next),
    .pc_set_next_i    (pc_set_next),
    .ir_i             (ir_i),
    .bank_i           (bank_i),
    .halt_i           (halt_i),
    .exc_i            (exc_i),
    .result_o         (result_o),
    .reg_write_addr_o (reg_write_addr_o),
    .reg_write_o      (reg_write_o),
    .pc_o             (pc_o),
    .pc_set_o         (pc_set_o),
    .ir_o             (ir_o),
    .bank_o           (bank_o),
    .halt_o           (halt_o),
    .exc_o            (exc_o)
  );

endmodule

//--- rtl/mem_stage_reg.sv
`timescale 1ns/1ns

module mem_stage_reg (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        stall_i,
  input  logic        bus_stall_i,
  input  logic [31:0] result_i,
  input  logic [31:0] load_data_i,
  input  logic [31:0] link_value_i,
  input  logic        link_sel_i,
  input  logic        load_sel_i,
  input  logic [3:0]  wb_addr_i,
  input  logic [1:0]  wb_mode_i,
  input  logic [31:0] pc_next_i,
  input  logic        pc_set_next_i,
  input  logic [63:0] ir_i,
  input  logic [3:0]  bank_i,
  input  logic        halt_i,
  input  logic        exc_i,
  output logic [31:0] result_o,
  output logic [3:0]  reg_write_addr_o,
  output logic [1:0]  reg_write_o,
  output logic [31:0] pc_o,
  output logic        pc_set_o,
  output logic [63:0] ir_o,
  output logic [3:0]  bank_o,
  output logic        halt_o,
  output logic        exc_o
);

  logic        hold;
  logic [31:0] result_sel;

  assign hold = stall_i || bus_stall_i;

  // link wins, then load data, else the execute result
  always_comb
  begin
    if (link_sel_i)
      result_sel = link_value_i;
    else if (load_sel_i)
      result_sel = load_data_i;
    else
      result_sel = result_i;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      result_o         <= 32'h0;
      reg_write_addr_o <= 4'h0;
      reg_write_o      <= cpu_pkg::WB_NONE;
      pc_o             <= 32'h0;
      pc_set_o         <= 1'b0;
      ir_o             <= 64'h0;
      bank_o           <= 4'h0;
      halt_o           <= 1'b0;
      exc_o            <= 1'b0;
    end
    else if (!hold)
    begin
      result_o         <= result_sel;
      reg_write_addr_o <= wb_addr_i;
      reg_write_o      <= wb_mode_i;
      pc_o             <= pc_next_i;
      pc_set_o         <= pc_set_next_i;
      ir_o             <= ir_i;
      bank_o           <= bank_i;
      halt_o           <= halt_i;
      exc_o            <= exc_i;
    end
  end

  // a stalled cycle leaves the whole bundle untouched at the next edge
  hold_keeps_outputs: assert property (
    @(posedge clk_i) disable iff (rst_i)
    hold |=> ($stable(result_o) && $stable(reg_write_addr_o) &&
              $stable(reg_write_o) && $stable(pc_o) && $stable(pc_set_o) &&
              $stable(ir_o) && $stable(bank_o) && $stable(halt_o) &&
              $stable(exc_o))
  ) else $error("stage outputs changed after a stalled cycle");

endmodule

//--- rtl/mem_wb_decode.sv
`timescale 1ns/1ns

module mem_wb_decode (
  input  logic [63:0] ir_i,
  input  logic [31:0] pc_i,
  input  logic [31:0] result_i,
  input  logic        exc_i,
  input  logic [1:0]  reg_write_i,
  input  logic        pc_set_i,
  output logic [3:0]  wb_addr_o,
  output logic [1:0]  wb_mode_o,
  output logic [31:0] pc_next_o,
  output logic        pc_set_next_o,
  output logic        link_sel_o,
  output logic        load_sel_o,
  output logic [31:0] link_value_o
);

  cpu_pkg::ir_type_e ir_type;
  logic [3:0]        ir_ra;

  assign ir_type = cpu_pkg::ir_type_e'(ir_i[cpu_pkg::IR_TYPE_MSB:cpu_pkg::IR_TYPE_LSB]);
  assign ir_ra   = ir_i[cpu_pkg::IR_RA_MSB:cpu_pkg::IR_RA_LSB];

  assign link_value_o = pc_i + cpu_pkg::LINK_OFFSET; // return address

  always_comb
  begin
    wb_addr_o     = ir_ra;
    wb_mode_o     = reg_write_i;
    pc_next_o     = pc_i;
    pc_set_next_o = pc_set_i;
    link_sel_o    = 1'b0;
    load_sel_o    = 1'b0;

    if (exc_i)
    begin
      // jump to the handler in result_i and save the return address
      wb_addr_o     = cpu_pkg::LINK_REG;
      wb_mode_o     = cpu_pkg::WB_BOTH;
      pc_next_o     = result_i;
      pc_set_next_o = 1'b1;
      link_sel_o    = 1'b1;
    end
    else if (ir_type == cpu_pkg::T_LOAD)
    begin
      load_sel_o = 1'b1;
    end
  end

  always_comb
  begin
    assert final (!(link_sel_o && load_sel_o))
      else $error("link and load data both selected");
  end

endmodule

//--- testbench/mem_bus_model.sv
`timescale 1ns/1ns

module mem_bus_model (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cyc_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_i,
  input  logic [3:0]  sel_i,
  output logic        ack_o,
  output logic [31:0] dat_o
);

  logic [31:0] mem [0:255];
  logic [1:0]  wait_cnt;
  logic [1:0]  delay;
  integer      seed;
  integer      i;

  initial
  begin
    seed = 32'h25e9;
    for (i = 0; i < 256; i = i + 1)
      mem[i] = (i * 32'h01030507) ^ 32'ha55a3cc3; // every address bit matters
  end

  assign dat_o = mem[adr_i[9:2]];
  assign ack_o = cyc_i && (wait_cnt == delay); // delay 0 acks at once

  always @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wait_cnt <= 2'd0;
      delay    <= 2'd0;
    end
    else if (cyc_i && ack_o)
    begin
      wait_cnt <= 2'd0;
      delay    <= $random(seed) & 3; // next access
      if (we_i)
      begin
        if (sel_i[3]) mem[adr_i[9:2]][31:24] <= dat_i[31:24];
        if (sel_i[2]) mem[adr_i[9:2]][23:16] <= dat_i[23:16];
        if (sel_i[1]) mem[adr_i[9:2]][15:8]  <= dat_i[15:8];
        if (sel_i[0]) mem[adr_i[9:2]][7:0]   <= dat_i[7:0];
      end
    end
    else if (cyc_i)
    begin
      wait_cnt <= wait_cnt + 2'd1;
    end
  end

endmodule

//--- testbench/mem_stage_tb.sv
`timescale 1ns/1ns

module mem_stage_tb;

  logic        clk_i, rst_i, stall_i, halt_i, pc_set_i, exc_i;
  logic [31:0] result_i, reg_data1_i, pc_i;
  logic [1:0]  reg_write_i;
  logic [63:0] ir_i;
  logic [3:0]  bank_i;
  logic        stall_o, halt_o, pc_set_o, exc_o, bus_we_o, bus_cyc_o, bus_ack;
  logic [31:0] result_o, pc_o, bus_adr_o, bus_dat_o, bus_rdata;
  logic [1:0]  reg_write_o;
  logic [63:0] ir_o;
  logic [3:0]  reg_write_addr_o, bank_o, bus_sel_o;

  logic [31:0] shadow_mem [0:255];
  logic        stim_on, will_accept;
  logic [31:0] exp_result, exp_pc;
  logic [3:0]  exp_addr, exp_bank;
  logic [1:0]  exp_wb;
  logic [63:0] exp_ir;
  logic        exp_pc_set, exp_halt, exp_exc;
  integer      seed, errors, checks, i, n;

  mem_stage u_mem_stage (.*, .bus_ack_i(bus_ack), .bus_dat_i(bus_rdata));

  mem_bus_model u_bus_model (
    .clk_i (clk_i), .rst_i (rst_i), .cyc_i (bus_cyc_o), .we_i (bus_we_o),
    .adr_i (bus_adr_o), .dat_i (bus_dat_o), .sel_i (bus_sel_o),
    .ack_o (bus_ack), .dat_o (bus_rdata)
  );

  // big-endian lane rule
  function automatic logic [3:0] lanes(input logic [1:0] size, input logic [1:0] adr);
    if (size == 2'd1)
      return adr[1] ? 4'b0011 : 4'b1100;
    if (size == 2'd2)
      return 4'b1000 >> adr;
    return 4'b1111;
  endfunction

  function automatic logic [31:0] extract(input logic [31:0] w, input logic [1:0] size,
                                          input logic [1:0] adr);
    if (size == 2'd1)
      return adr[1] ? (w & 32'hffff) : (w >> 16);
    if (size == 2'd2)
      return (w >> (8 * (3 - adr))) & 32'hff;
    return w;
  endfunction

  function automatic logic is_mem(input logic [63:0] ir);
    return ir[31:28] == cpu_pkg::T_LOAD || ir[31:28] == cpu_pkg::T_STORE;
  endfunction

  task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
    errors = errors + 1;
    $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic note_failure(input string what);
    errors = errors + 1;
    $display("[ERROR] %0t %s", $time, what);
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(negedge clk_i)
    will_accept <= !rst_i && stim_on && !stall_i && !stall_o; // next edge captures

  // expected bundle from the accepted inputs
  always @(posedge clk_i)
  begin
    logic [31:0] w;
    logic [3:0]  sel;
    if (will_accept)
    begin
      checks     = checks + 1;
      w          = shadow_mem[result_i[9:2]];
      sel        = lanes(ir_i[25:24], result_i[1:0]);
      exp_ir     <= ir_i;
      exp_bank   <= bank_i;
      exp_halt   <= halt_i;
      exp_exc    <= exc_i;
      exp_addr   <= exc_i ? cpu_pkg::LINK_REG : ir_i[cpu_pkg::IR_RA_MSB:cpu_pkg::IR_RA_LSB];
      exp_wb     <= exc_i ? cpu_pkg::WB_BOTH : reg_write_i;
      exp_pc     <= exc_i ? result_i : pc_i;
      exp_pc_set <= exc_i ? 1'b1 : pc_set_i;
      if (exc_i)
        exp_result <= pc_i + cpu_pkg::LINK_OFFSET;
      else if (ir_i[31:28] == cpu_pkg::T_LOAD)
        exp_result <= extract(w, ir_i[25:24], result_i[1:0]);
      else
        exp_result <= result_i;
      if (!exc_i && ir_i[31:28] == cpu_pkg::T_STORE)
      begin
        if (sel[3]) w[31:24] = reg_data1_i[31:24];
        if (sel[2]) w[23:16] = reg_data1_i[23:16];
        if (sel[1]) w[15:8]  = reg_data1_i[15:8];
        if (sel[0]) w[7:0]   = reg_data1_i[7:0];
        shadow_mem[result_i[9:2]] <= w;
      end
    end
  end

  idle_zero: assert property (@(posedge clk_i) disable iff (rst_i) !stim_on |->
    (result_o == 0 && pc_o == 0 && !pc_set_o && ir_o == 0 && bank_o == 0 && !halt_o &&
     !exc_o && reg_write_o == 0 && reg_write_addr_o == 0 && !stall_o))
    else note_failure("registered outputs or stall_o not zero after reset");
  bus_request: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_cyc_o == (is_mem(ir_i) && !exc_i))
    else mismatch("bus_cyc_o", $sampled(bus_cyc_o), !$sampled(bus_cyc_o));
  stall_level: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_o == (is_mem(ir_i) && !exc_i && !bus_ack))
    else mismatch("stall_o", $sampled(stall_o), !$sampled(stall_o));
  store_we: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_cyc_o |-> bus_we_o == (ir_i[31:28] == cpu_pkg::T_STORE))
    else mismatch("bus_we_o", $sampled(bus_we_o), !$sampled(bus_we_o));
  store_adr: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_cyc_o |-> bus_adr_o == result_i)
    else mismatch("bus_adr_o", $sampled(bus_adr_o), $sampled(result_i));
  store_dat: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_we_o |-> bus_dat_o == reg_data1_i)
    else mismatch("bus_dat_o", $sampled(bus_dat_o), $sampled(reg_data1_i));
  lane_sel: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_cyc_o |-> bus_sel_o == lanes(ir_i[25:24], result_i[1:0]))
    else mismatch("bus_sel_o", $sampled(bus_sel_o),
                  lanes($sampled(ir_i[25:24]), $sampled(result_i[1:0])));
  out_result: assert property (@(posedge clk_i) will_accept |=> result_o == exp_result)
    else mismatch("result_o", $sampled(result_o), $sampled(exp_result));
  out_pc: assert property (@(posedge clk_i) will_accept |=> pc_o == exp_pc)
    else mismatch("pc_o", $sampled(pc_o), $sampled(exp_pc));
  out_pc_set: assert property (@(posedge clk_i) will_accept |=> pc_set_o == exp_pc_set)
    else mismatch("pc_set_o", $sampled(pc_set_o), $sampled(exp_pc_set));
  out_wb_addr: assert property (@(posedge clk_i) will_accept |=> reg_write_addr_o == exp_addr)
    else mismatch("reg_write_addr_o", $sampled(reg_write_addr_o), $sampled(exp_addr));
  out_wb_mode: assert property (@(posedge clk_i) will_accept |=> reg_write_o == exp_wb)
    else mismatch("reg_write_o", $sampled(reg_write_o), $sampled(exp_wb));
  out_ir: assert property (@(posedge clk_i) will_accept |=> ir_o == exp_ir)
    else mismatch("ir_o", $sampled(ir_o), $sampled(exp_ir));
  out_bank: assert property (@(posedge clk_i) will_accept |=> bank_o == exp_bank)
    else mismatch("bank_o", $sampled(bank_o), $sampled(exp_bank));
  out_halt: assert property (@(posedge clk_i) will_accept |=> halt_o == exp_halt)
    else mismatch("halt_o", $sampled(halt_o), $sampled(exp_halt));
  out_exc: assert property (@(posedge clk_i) will_accept |=> exc_o == exp_exc)
    else mismatch("exc_o", $sampled(exc_o), $sampled(exp_exc));
  stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (stall_i || stall_o) |=> ($stable(result_o) && $stable(pc_o) && $stable(ir_o) &&
    $stable(pc_set_o) && $stable(reg_write_o) && $stable(reg_write_addr_o) &&
    $stable(bank_o) && $stable(halt_o) && $stable(exc_o)))
    else note_failure("registered outputs changed after a stalled cycle");

  initial
  begin
    seed = 32'h25e9;
    errors = 0;
    checks = 0;
    for (i = 0; i < 256; i = i + 1)
      shadow_mem[i] = (i * 32'h01030507) ^ 32'ha55a3cc3;
    rst_i       = 1'b1;
    stim_on     = 1'b0;
    will_accept = 1'b0;
    stall_i     = 1'b0;
    halt_i      = 1'b0;
    pc_set_i    = 1'b0;
    exc_i       = 1'b0;
    result_i    = 0;
    reg_data1_i = 0;
    pc_i        = 0;
    reg_write_i = 0;
    ir_i        = 0;
    bank_i      = 0;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    for (n = 0; n < 300; n = n + 1)
    begin
      drive_bundle();
      wait_accept();
    end
    repeat (4) @(posedge clk_i);
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic drive_bundle();
    logic [63:0] ir;
    logic [3:0]  t;
    @(posedge clk_i);
    t = {$random(seed)} % 8;
    if (t > 5)
      t = t - 4; // extra loads and stores
    ir = {$random(seed), $random(seed)};
    ir[31:28] = t;
    ir_i        <= ir;
    result_i    <= (ir[31:28] == cpu_pkg::T_LOAD || t == 3) ? ($random(seed) & 32'h3ff) :
                   $random(seed);
    reg_data1_i <= $random(seed);
    pc_i        <= $random(seed);
    reg_write_i <= $random(seed);
    pc_set_i    <= $random(seed);
    halt_i      <= $random(seed);
    bank_i      <= $random(seed);
    exc_i       <= ({$random(seed)} % 8) == 0;
    stall_i     <= ({$random(seed)} % 4) == 0;
    stim_on     <= 1'b1;
  endtask

  task automatic wait_accept();
    integer cnt;
    cnt = 0;
    forever
    begin
      @(negedge clk_i);
      if (!stall_i && !stall_o)
        break;
      cnt = cnt + 1;
      if (cnt > 20)
      begin
        $display("timeout: bundle not accepted within 20 cycles");
        $display("Simulation finished: FAIL");
        $finish;
      end
      @(posedge clk_i);
      stall_i <= ({$random(seed)} % 4) == 0;
    end
  endtask

endmodule

//--- vlog.f
rtl/cpu_pkg.sv
rtl/mem_bus_ctrl.sv
rtl/mem_wb_decode.sv
rtl/mem_stage_reg.sv
rtl/mem_stage.sv
testbench/mem_bus_model.sv
testbench/mem_stage_tb.sv
